/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_echo_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard design/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/uart_line_tasks.svh */
// one full frame on rxd, lsb first, 64 clocks per bit
task automatic send_frame(input logic [7:0] data, input logic stop_bit);
  int i;
  rxd = 1'b0;
  repeat (BIT_CLKS) @(negedge sys_clk);
  for (i = 0; i < 8; i++) begin
    rxd = data[i];
    repeat (BIT_CLKS) @(negedge sys_clk);
  end
  rxd = stop_bit;
  if (stop_bit) begin
    repeat (BIT_CLKS) @(negedge sys_clk);
  end else begin
    // bad stop held past its centre, then back to mark
    repeat (BIT_CLKS * 3 / 4) @(negedge sys_clk);
    rxd = 1'b1;
  end
endtask

task automatic idle_line(input int clks);
  rxd = 1'b1;
  repeat (clks) @(negedge sys_clk);
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

task automatic fail_plain(input string what);
  errors++;
  $display("%s", what);
endtask

/* bench/uart_echo_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_echo_tb;

  localparam int BIT_CLKS = uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV;

  logic sys_clk;
  logic sys_rst_l;
  logic rxd;
  logic pause;
  logic txd;
  logic frame_err;
  logic overflow;

  int errors;
  int checks;
  int tests;
  int err_pulses;
  int low_while_paused;
  logic [31:0] rng;

  logic [7:0] exp_q[$];
  logic [7:0] got_q[$];
  logic       stop_q[$];

  // txd decoder state
  logic       dec_busy;
  int         dec_cnt;
  logic [7:0] dec_shreg;

  uart_echo_top uart_echo_top_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .rxd       (rxd),
    .pause     (pause),
    .txd       (txd),
    .frame_err (frame_err),
    .overflow  (overflow)
  );

  `include "uart_line_tasks.svh"

  always #5 sys_clk = ~sys_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // samples txd at bit centres counted from the falling start edge
  always @(negedge sys_clk) begin
    if (frame_err) err_pulses++;
    if (pause && !txd) low_while_paused++;
    if (!dec_busy) begin
      if (sys_rst_l && !txd) begin
        dec_busy = 1'b1;
        dec_cnt  = 0;
      end
    end else begin
      dec_cnt++;
      if (dec_cnt == BIT_CLKS / 2) begin
        if (txd) dec_busy = 1'b0; // not a real start bit
      end else if (dec_cnt > BIT_CLKS / 2 && (dec_cnt - BIT_CLKS / 2) % BIT_CLKS == 0) begin
        if ((dec_cnt - BIT_CLKS / 2) / BIT_CLKS <= 8) begin
          dec_shreg = {txd, dec_shreg[7:1]};
        end else begin
          got_q.push_back(dec_shreg);
          stop_q.push_back(txd);
          dec_busy = 1'b0;
        end
      end
    end
  end

  task automatic wait_echo(input int n);
    int t;
    t = 0;
    while (got_q.size() < n && t < n * 800 + 4000) begin
      @(negedge sys_clk);
      t++;
    end
    if (got_q.size() < n) fail_plain("timeout waiting for echoed bytes on txd");
  endtask

  // compares everything decoded so far with the model, in order
  task automatic compare_echo();
    check_bit("echo count", got_q.size() == exp_q.size(), 1'b1);
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      check_byte("txd byte", got_q.pop_front(), exp_q.pop_front());
      check_bit("txd stop bit", stop_q.pop_front(), 1'b1);
    end
    got_q.delete();
    stop_q.delete();
    exp_q.delete();
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  task automatic send_good(input logic [7:0] b);
    send_frame(b, 1'b1);
    exp_q.push_back(b);
  endtask

  initial begin
    int e0;
    int i;
    int t;
    int base;
    logic [7:0] b;
    sys_clk = 1'b0;
    sys_rst_l = 1'b0;
    rxd = 1'b1;
    pause = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    err_pulses = 0;
    low_while_paused = 0;
    dec_busy = 1'b0;
    dec_cnt = 0;
    dec_shreg = '0;
    rng = 32'd96;
    repeat (10) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_l = 1'b1;

    e0 = errors;
    for (i = 0; i < 200 && errors == e0; i++) begin
      @(negedge sys_clk);
      check_bit("txd", txd, 1'b1);
      check_bit("overflow", overflow, 1'b0);
      check_bit("frame_err", frame_err, 1'b0);
    end
    report("reset idle", e0);

    e0 = errors;
    base = err_pulses;
    for (i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      b = rng[7:0];
      send_good(b);
      rng = xorshift(rng);
      idle_line(int'(rng[6:0]));
    end
    wait_echo(20);
    compare_echo();
    check_bit("frame_err during echo", err_pulses != base, 1'b0);
    report("random echo", e0);

    e0 = errors;
    base = err_pulses;
    send_frame(8'h5a, 1'b0);
    t = 0;
    // send_frame returns a quarter bit past the stop centre
    while (err_pulses == base && t < BIT_CLKS * 3 / 4) begin
      @(negedge sys_clk);
      t++;
    end
    check_bit("frame_err pulse", err_pulses == base + 1, 1'b1);
    idle_line(2 * BIT_CLKS);
    send_good(8'hc3);
    wait_echo(1);
    compare_echo();
    report("framing error", e0);

    e0 = errors;
    base = err_pulses;
    rxd = 1'b0;
    repeat (3 * uart_pkg::BAUD_DIV) @(negedge sys_clk);
    idle_line(20 * BIT_CLKS);
    check_bit("frame_err after glitch", err_pulses != base, 1'b0);
    check_bit("txd quiet after glitch", got_q.size() != 0 || dec_busy, 1'b0);
    send_good(8'h3c);
    wait_echo(1);
    compare_echo();
    report("glitch reject", e0);

    e0 = errors;
    pause = 1'b1;
    low_while_paused = 0;
    for (i = 0; i < 10; i++) begin
      if (i == uart_pkg::FIFO_DEPTH) check_bit("overflow before full", overflow, 1'b0);
      rng = xorshift(rng);
      b = rng[7:0];
      send_frame(b, 1'b1);
      if (i < uart_pkg::FIFO_DEPTH) exp_q.push_back(b);
      idle_line(8);
    end
    idle_line(BIT_CLKS);
    check_bit("txd low while paused", low_while_paused != 0, 1'b0);
    pause = 1'b0;
    wait_echo(uart_pkg::FIFO_DEPTH);
    idle_line(12 * BIT_CLKS); // anything extra would show up here
    compare_echo();
    check_bit("overflow", overflow, 1'b1);
    report("pause and overflow", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #5_000_000;
    $display("simulation ran too long and was stopped");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* design/baud_tick_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen (
  input  logic sys_clk,
  input  logic sys_rst_l,
  output logic baud_tick
);

  logic [uart_pkg::BAUD_W-1:0] div_cnt;

  // free running divider, one tick per wrap
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      div_cnt   <= '0;
      baud_tick <= 1'b0;
    end else if (div_cnt == uart_pkg::BAUD_LAST) begin
      div_cnt   <= '0;
      baud_tick <= 1'b1;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      baud_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/byte_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo (
  input  logic       sys_clk,
  input  logic       sys_rst_l,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       pop,
  output logic [7:0] head,
  output logic       empty,
  output logic       overflow
);

  logic [7:0] mem [uart_pkg::FIFO_DEPTH];

  logic [uart_pkg::PTR_W-1:0] wr_ptr;
  logic [uart_pkg::PTR_W-1:0] rd_ptr;
  logic [uart_pkg::CNT_W-1:0] count;

  logic full;
  logic do_push;
  logic do_pop;

  assign full    = (count == uart_pkg::FIFO_FULL);
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr]; // oldest byte

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && full) begin
        overflow <= 1'b1; // byte lost, held until reset
      end
    end
  end

  a_no_pop_empty: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l) pop |-> !empty
  );

endmodule

`default_nettype wire

/* design/uart_echo_top.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_echo_top (
  input  logic sys_clk,
  input  logic sys_rst_l,
  input  logic rxd,
  input  logic pause,
  output logic txd,
  output logic frame_err,
  output logic overflow
);

  logic                baud_tick;
  logic                rx_valid;
  uart_pkg::rx_frame_t rx_frame;
  logic                push;
  logic                pop;
  logic                empty;
  logic [7:0]          head;

  // only good frames reach the fifo
  assign push      = rx_valid && !rx_frame.frame_err;
  assign frame_err = rx_valid && rx_frame.frame_err;

  baud_tick_gen baud_tick_gen_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick)
  );

  uart_rx uart_rx_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick),
    .rxd       (rxd),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame)
  );

  byte_fifo byte_fifo_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .push      (push),
    .push_data (rx_frame.data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .overflow  (overflow)
  );

  uart_tx uart_tx_i (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick),
    .empty     (empty),
    .head      (head),
    .pause     (pause),
    .pop       (pop),
    .txd       (txd)
  );

endmodule

`default_nettype wire

/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // frame format and oversampling
  localparam int DATA_BITS  = 8;
  localparam int OVERSAMPLE = 16;
  localparam int HALF_BIT   = 8;
  localparam int BAUD_DIV   = 4;   // sys_clk cycles per baud tick
  localparam int FIFO_DEPTH = 8;

  // counter widths
  localparam int BAUD_W = $clog2(BAUD_DIV);
  localparam int TICK_W = $clog2(OVERSAMPLE);
  localparam int BIT_W  = $clog2(DATA_BITS + 1);
  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

  // terminal counts, sized to their counters
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
  localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(HALF_BIT - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_BITS - 1);
  localparam logic [BIT_W-1:0]  BIT_ALL   = BIT_W'(DATA_BITS);
  localparam logic [CNT_W-1:0]  FIFO_FULL = CNT_W'(FIFO_DEPTH);

  typedef struct packed {
    logic                 frame_err; // stop bit was low
    logic [DATA_BITS-1:0] data;
  } rx_frame_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_CENTRE,
    RX_WAIT,
    RX_SAMPLE,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  logic                sys_clk,
  input  logic                sys_rst_l,
  input  logic                baud_tick,
  input  logic                rxd,
  output logic                rx_valid,
  output uart_pkg::rx_frame_t rx_frame
);

  logic rx_meta;
  logic rx_sync;

  uart_pkg::rx_state_t state;

  logic [uart_pkg::TICK_W-1:0]    tick_cnt;
  logic [uart_pkg::BIT_W-1:0]     bit_cnt;
  logic [uart_pkg::DATA_BITS-1:0] shreg;

  // two stage synchronizer, idles at mark level
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state    <= uart_pkg::RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (!rx_sync) begin
            state <= uart_pkg::RX_CENTRE; // falling edge of start bit
          end
        end
        uart_pkg::RX_CENTRE: begin
          if (baud_tick) begin
            if (tick_cnt == uart_pkg::TICK_HALF) begin
              tick_cnt <= '0;
              // line back high at mid start bit means a glitch
              if (rx_sync) begin
                state <= uart_pkg::RX_IDLE;
              end else begin
                state <= uart_pkg::RX_WAIT;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        uart_pkg::RX_WAIT: begin
          if (baud_tick) begin
            if (tick_cnt == uart_pkg::TICK_LAST) begin
              tick_cnt <= '0;
              if (bit_cnt == uart_pkg::BIT_ALL) begin
                state <= uart_pkg::RX_STOP;
              end else begin
                state <= uart_pkg::RX_SAMPLE;
              end
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end
        uart_pkg::RX_SAMPLE: begin
          bit_cnt <= bit_cnt + 1'b1;
          state   <= uart_pkg::RX_WAIT;
        end
        uart_pkg::RX_STOP: begin
          rx_valid <= 1'b1;
          state    <= uart_pkg::RX_IDLE;
        end
        default: begin
          state <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data path, lsb arrives first so shift towards bit 0
  always_ff @(posedge sys_clk) begin
    if (state == uart_pkg::RX_SAMPLE) begin
      shreg <= {rx_sync, shreg[uart_pkg::DATA_BITS-1:1]};
    end
    if (state == uart_pkg::RX_STOP) begin
      rx_frame.data      <= shreg;
      rx_frame.frame_err <= ~rx_sync;
    end
  end

  a_valid_single: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l) rx_valid |=> !rx_valid
  );

  a_state_legal: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l)
    state inside {uart_pkg::RX_IDLE, uart_pkg::RX_CENTRE, uart_pkg::RX_WAIT,
                  uart_pkg::RX_SAMPLE, uart_pkg::RX_STOP}
  );

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  logic       sys_clk,
  input  logic       sys_rst_l,
  input  logic       baud_tick,
  input  logic       empty,
  input  logic [7:0] head,
  input  logic       pause,
  output logic       pop,
  output logic       txd
);

  uart_pkg::tx_state_t state;

  logic [uart_pkg::TICK_W-1:0]    tick_cnt;
  logic [uart_pkg::BIT_W-1:0]     bit_cnt;
  logic [uart_pkg::DATA_BITS-1:0] shreg;

  logic bit_end;
  logic shift_en;

  assign pop      = (state == uart_pkg::TX_IDLE) && !empty && !pause;
  assign bit_end  = baud_tick && (tick_cnt == uart_pkg::TICK_LAST);
  assign shift_en = bit_end &&
                    (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA);

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state    <= uart_pkg::TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (pop) begin
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (baud_tick && txd) begin
            txd <= 1'b0; // start bit aligned to the tick
          end else if (bit_end) begin
            tick_cnt <= '0;
            txd      <= shreg[0];
            state    <= uart_pkg::TX_DATA;
          end else if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == uart_pkg::BIT_LAST) begin
              txd   <= 1'b1;
              state <= uart_pkg::TX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              txd     <= shreg[0];
            end
          end else if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) begin
            tick_cnt <= '0;
            state    <= uart_pkg::TX_IDLE;
          end else if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // byte captured on pop, then shifted out lsb first
  always_ff @(posedge sys_clk) begin
    if (pop) begin
      shreg <= head;
    end else if (shift_en) begin
      shreg <= shreg >> 1;
    end
  end

  a_idle_mark: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_l) (state == uart_pkg::TX_IDLE) |-> txd
  );

endmodule

`default_nettype wire

/* sim.f */
design/uart_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_echo_top.sv
+incdir+bench
bench/uart_echo_tb.sv
